//--- source/supervisor_defs.svh
`ifndef SUPERVISOR_DEFS_SVH
`define SUPERVISOR_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// reset line timing
////////////////////////////////////////////////////////////////////////////

// count at which a held reset line is let go
// hardware build uses 32_000_000 with a wider hold counter
`define RESET_HOLD_CYCLES 40

`define HOLD_COUNT_WIDTH 8

////////////////////////////////////////////////////////////////////////////
// status counters and led patterns
////////////////////////////////////////////////////////////////////////////

`define EVENT_COUNT_WIDTH 16

`define LED_COUNT_WIDTH 12

// period select bits of the pattern counter
`define GLOW_SLOW_BIT 11
`define GLOW_FAST_BIT 8
`define BLINK_BIT 10

`endif

//--- source/supervisor_pkg.sv
`default_nettype none

`include "supervisor_defs.svh"

package supervisor_pkg;

    typedef logic [`HOLD_COUNT_WIDTH-1:0] hold_count_t;
    typedef logic [`EVENT_COUNT_WIDTH-1:0] event_count_t;
    typedef logic [`LED_COUNT_WIDTH-1:0] led_count_t;

    // what the multi-purpose pin is wired to on the board
    typedef enum logic [1:0] {
        PIN_LED      = 2'd0,
        PIN_GDEMU    = 2'd1,
        PIN_USBGDROM = 2'd2,
        PIN_MODE     = 2'd3
    } pin_mode_t;

    typedef enum logic [2:0] {
        LED_NO_PLL  = 3'd0,
        LED_RESYNC  = 3'd1,
        LED_FORCED  = 3'd2,
        LED_READY   = 3'd3,
        LED_WAITING = 3'd4
    } led_state_t;

    typedef struct packed {
        logic slow_glow;
        logic fast_glow;
        logic dim;
        logic blink;
    } led_patterns_t;

    // pin floats while drive_en is low
    typedef struct packed {
        logic drive_en;
        logic level;
    } open_drain_t;

    typedef struct packed {
        event_count_t pll54_losses;
        event_count_t pll_hdmi_losses;
        event_count_t resyncs;
    } event_counts_t;

endpackage

`default_nettype wire

//--- source/console_reset_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "supervisor_defs.svh"

module console_reset_timer
    import supervisor_pkg::*;
(
    input  logic control_clock,
    input  logic reset_dc,
    input  logic request,
    output logic hold
);

    localparam hold_count_t HOLD_LIMIT = hold_count_t'(`RESET_HOLD_CYCLES);

    hold_count_t count;

    // a request restarts the hold window, so back to back requests
    // keep the line low until the last one has aged out
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            hold  <= 1'b0;
            count <= '0;
        end else if (request) begin
            hold  <= 1'b1;
            count <= '0;
        end else if (hold) begin
            if (count == HOLD_LIMIT) begin
                hold <= 1'b0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // window length is bounded for every held cycle
    hold_count_in_range: assert property (
        @(posedge control_clock) disable iff (reset_dc)
        hold |-> (count <= HOLD_LIMIT)
    );

    // line drops the cycle after a request and stays down long enough
    hold_follows_request: assert property (
        @(posedge control_clock) disable iff (reset_dc)
        request |=> hold [*`RESET_HOLD_CYCLES + 1]
    );

endmodule

`default_nettype wire

//--- source/led_pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "supervisor_defs.svh"

module led_pattern_gen
    import supervisor_pkg::*;
(
    input  logic          control_clock,
    input  logic          reset_dc,
    output led_patterns_t patterns
);

    led_count_t count;
    logic [3:0] phase;
    logic       slow_glow;
    logic       fast_glow;

    // triangle ramp from the 4 bits under the glow bit, compared against
    // the pwm phase
    function automatic logic glow_level(input led_count_t cnt, input int unsigned bitpos);
        logic [3:0] brightness;
        brightness = 4'(cnt >> (bitpos - 4));
        if (cnt[bitpos]) begin
            brightness = ~brightness;
        end
        return cnt[3:0] < brightness;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // free running pattern counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign phase = count[3:0];

    ////////////////////////////////////////////////////////////////////////////
    // waveforms
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        slow_glow = glow_level(count, `GLOW_SLOW_BIT);
        fast_glow = glow_level(count, `GLOW_FAST_BIT);
    end

    always_comb begin
        patterns.slow_glow = slow_glow;
        patterns.fast_glow = fast_glow;
        // one pwm slot in sixteen
        patterns.dim       = (phase == 4'd0);
        // fast glow gated by the blink bit
        patterns.blink     = count[`BLINK_BIT] ? fast_glow : 1'b0;
    end

endmodule

`default_nettype wire

//--- source/status_led_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "supervisor_defs.svh"

module status_led_fsm
    import supervisor_pkg::*;
(
    input  logic          control_clock,
    input  logic          reset_dc,
    input  pin_mode_t     pin_mode,
    input  logic          pll_ready,
    input  logic          resync,
    input  logic          force_generate,
    input  logic          encoder_ready,
    input  led_patterns_t patterns,
    input  logic          dc_hold,
    input  logic          opt_hold,
    output open_drain_t   status_pin
);

    led_state_t  state;
    led_state_t  next_state;
    open_drain_t pin_next;

    ////////////////////////////////////////////////////////////////////////////
    // state selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (!pll_ready) begin
            next_state = LED_NO_PLL;
        end else if (resync) begin
            next_state = LED_RESYNC;
        end else if (force_generate) begin
            next_state = LED_FORCED;
        end else if (encoder_ready) begin
            next_state = LED_READY;
        end else begin
            next_state = LED_WAITING;
        end
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            state <= LED_NO_PLL;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pin output
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        pin_next = '0;
        case (pin_mode)
            PIN_LED: begin
                // led sits between the pin and the supply, so low lights it
                pin_next.drive_en = 1'b1;
                case (state)
                    LED_NO_PLL:  pin_next.level = ~patterns.dim;
                    LED_RESYNC:  pin_next.level = ~patterns.fast_glow;
                    LED_FORCED:  pin_next.level = ~patterns.blink;
                    LED_READY:   pin_next.level = 1'b0;
                    default:     pin_next.level = ~patterns.slow_glow;
                endcase
            end
            PIN_GDEMU, PIN_MODE: begin
                pin_next.drive_en = opt_hold;
            end
            PIN_USBGDROM: begin
                pin_next.drive_en = dc_hold;
            end
            default: begin
                pin_next = '0;
            end
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            status_pin <= '0;
        end else begin
            status_pin <= pin_next;
        end
    end

    // a reset mirror never pulls the pin high
    mirror_drives_low: assert property (
        @(posedge control_clock) disable iff (reset_dc)
        (status_pin.drive_en && ($past(pin_mode) != PIN_LED)) |-> !status_pin.level
    );

endmodule

`default_nettype wire

//--- source/lockloss_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "supervisor_defs.svh"

module lockloss_monitor
    import supervisor_pkg::*;
(
    input  logic          control_clock,
    input  logic          reset_dc,
    input  logic          pll54_locked,
    input  logic          pll_hdmi_locked,
    input  logic          resync,
    output logic          pll_ready,
    output event_counts_t event_counts
);

    // bit 0 is the 54 MHz pll, bit 1 the hdmi pll
    logic [1:0] lock_meta;
    logic [1:0] lock_sync;
    logic [1:0] lock_prev;
    logic [1:0] lock_fall;

    logic resync_q;
    logic resync_prev;
    logic resync_rise;

    ////////////////////////////////////////////////////////////////////////////
    // synchronizers and edge detect
    ////////////////////////////////////////////////////////////////////////////

    // sync chain comes out of reset reading locked
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            lock_meta   <= 2'b11;
            lock_sync   <= 2'b11;
            lock_prev   <= 2'b11;
            resync_q    <= 1'b0;
            resync_prev <= 1'b0;
        end else begin
            lock_meta   <= {pll_hdmi_locked, pll54_locked};
            lock_sync   <= lock_meta;
            lock_prev   <= lock_sync;
            resync_q    <= resync;
            resync_prev <= resync_q;
        end
    end

    assign lock_fall   = lock_prev & ~lock_sync;
    assign resync_rise = resync_q & ~resync_prev;

    assign pll_ready = lock_sync[0];

    ////////////////////////////////////////////////////////////////////////////
    // event counters
    ////////////////////////////////////////////////////////////////////////////

    // counters wrap
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            event_counts <= '0;
        end else begin
            if (lock_fall[0]) begin
                event_counts.pll54_losses <= event_counts.pll54_losses + 1'b1;
            end
            if (lock_fall[1]) begin
                event_counts.pll_hdmi_losses <= event_counts.pll_hdmi_losses + 1'b1;
            end
            if (resync_rise) begin
                event_counts.resyncs <= event_counts.resyncs + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/control_supervisor.sv
`timescale 1ns/1ps
`default_nettype none

`include "supervisor_defs.svh"

module control_supervisor
    import supervisor_pkg::*;
(
    input  logic          control_clock,
    input  logic          reset_dc,

    // reset requests, held high for as long as the reset is wanted
    input  logic          dc_reset_request,
    input  logic          opt_reset_request,

    input  pin_mode_t     pin_mode,

    // straight from the pll lock pins
    input  logic          pll54_locked,
    input  logic          pll_hdmi_locked,

    input  logic          resync,
    input  logic          force_generate,
    input  logic          encoder_ready,

    output open_drain_t   dc_nreset,
    output open_drain_t   status_pin,
    output event_counts_t event_counts
);

    logic          dc_hold;
    logic          opt_hold;
    logic          pll_ready;
    led_patterns_t patterns;

    ////////////////////////////////////////////////////////////////////////////
    // reset lines
    ////////////////////////////////////////////////////////////////////////////

    console_reset_timer dc_reset_timer (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (dc_reset_request),
        .hold          (dc_hold)
    );

    // optional drive reset, only reachable through the status pin
    console_reset_timer opt_reset_timer (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (opt_reset_request),
        .hold          (opt_hold)
    );

    assign dc_nreset = '{drive_en: dc_hold, level: 1'b0};

    ////////////////////////////////////////////////////////////////////////////
    // status pin and monitors
    ////////////////////////////////////////////////////////////////////////////

    led_pattern_gen i_led_pattern_gen (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .patterns      (patterns)
    );

    lockloss_monitor i_lockloss_monitor (
        .control_clock   (control_clock),
        .reset_dc        (reset_dc),
        .pll54_locked    (pll54_locked),
        .pll_hdmi_locked (pll_hdmi_locked),
        .resync          (resync),
        .pll_ready       (pll_ready),
        .event_counts    (event_counts)
    );

    status_led_fsm i_status_led_fsm (
        .control_clock  (control_clock),
        .reset_dc       (reset_dc),
        .pin_mode       (pin_mode),
        .pll_ready      (pll_ready),
        .resync         (resync),
        .force_generate (force_generate),
        .encoder_ready  (encoder_ready),
        .patterns       (patterns),
        .dc_hold        (dc_hold),
        .opt_hold       (opt_hold),
        .status_pin     (status_pin)
    );

endmodule

`default_nettype wire

//--- tests/tb_control_supervisor.sv
`timescale 1ns/1ps
`default_nettype none

`include "supervisor_defs.svh"

module tb_control_supervisor
    import supervisor_pkg::*;
();

    localparam int MAX_CYCLES  = 4000;
    localparam int HOLD_CYCLES = `RESET_HOLD_CYCLES;

    logic          control_clock;
    logic          reset_dc;
    logic          dc_reset_request;
    logic          opt_reset_request;
    pin_mode_t     pin_mode;
    logic          pll54_locked;
    logic          pll_hdmi_locked;
    logic          resync;
    logic          force_generate;
    logic          encoder_ready;
    open_drain_t   dc_nreset;
    open_drain_t   status_pin;
    event_counts_t event_counts;

    integer seed;
    int     cycle_count;
    int     dc_errors;
    int     pin_errors;
    int     count_errors;
    int     driven_54_falls;
    int     driven_hdmi_falls;
    int     driven_rises;

    // reference model state
    logic         m_dc_hold;
    logic         m_opt_hold;
    int           m_dc_since;
    int           m_opt_since;
    led_count_t   m_led_cnt;
    logic [1:0]   m_meta;
    logic [1:0]   m_sync;
    logic [1:0]   m_prev;
    logic         m_rs_q;
    logic         m_rs_prev;
    led_state_t   m_state;
    open_drain_t  m_pin;
    event_count_t m_cnt54;
    event_count_t m_cnthdmi;
    event_count_t m_cntrs;

    control_supervisor i_control_supervisor (
        .control_clock     (control_clock),
        .reset_dc          (reset_dc),
        .dc_reset_request  (dc_reset_request),
        .opt_reset_request (opt_reset_request),
        .pin_mode          (pin_mode),
        .pll54_locked      (pll54_locked),
        .pll_hdmi_locked   (pll_hdmi_locked),
        .resync            (resync),
        .force_generate    (force_generate),
        .encoder_ready     (encoder_ready),
        .dc_nreset         (dc_nreset),
        .status_pin        (status_pin),
        .event_counts      (event_counts)
    );

    initial begin
        control_clock = 1'b0;
        forever #50 control_clock = ~control_clock;
    end

    always @(posedge control_clock) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= MAX_CYCLES);
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    // ramp bits flip on the upper half of the glow period
    function automatic logic glow_wave(input led_count_t cnt, input int top);
        logic [3:0] ramp;
        for (int i = 0; i < 4; i++) begin
            ramp[i] = cnt[top - 4 + i] ^ cnt[top];
        end
        return cnt[3:0] < ramp;
    endfunction

    function automatic open_drain_t pin_choice(input pin_mode_t mode, input led_state_t st,
                                               input led_count_t cnt, input logic dch,
                                               input logic opth);
        open_drain_t pin;
        logic        fast;
        fast = glow_wave(cnt, `GLOW_FAST_BIT);
        pin  = '0;
        if (mode == PIN_LED) begin
            pin.drive_en = 1'b1;
            case (st)
                LED_NO_PLL: pin.level = (cnt[3:0] != 4'd0);
                LED_RESYNC: pin.level = !fast;
                LED_FORCED: pin.level = !(fast && cnt[`BLINK_BIT]);
                LED_READY:  pin.level = 1'b0;
                default:    pin.level = !glow_wave(cnt, `GLOW_SLOW_BIT);
            endcase
        end else if (mode == PIN_USBGDROM) begin
            pin.drive_en = dch;
        end else begin
            pin.drive_en = opth;
        end
        return pin;
    endfunction

    task automatic stretch_hold(input logic req, inout logic held, inout int since);
        if (req) begin
            held  = 1'b1;
            since = 0;
        end else if (held) begin
            since++;
            if (since > HOLD_CYCLES) begin
                held = 1'b0;
            end
        end
    endtask

    task update_model;
        logic [1:0]  fall;
        logic        rise;
        led_state_t  nxt;
        open_drain_t pin_n;
        fall  = m_prev & ~m_sync;
        rise  = m_rs_q & ~m_rs_prev;
        pin_n = pin_choice(pin_mode, m_state, m_led_cnt, m_dc_hold, m_opt_hold);
        if (!m_sync[0]) begin
            nxt = LED_NO_PLL;
        end else if (resync) begin
            nxt = LED_RESYNC;
        end else if (force_generate) begin
            nxt = LED_FORCED;
        end else if (encoder_ready) begin
            nxt = LED_READY;
        end else begin
            nxt = LED_WAITING;
        end
        if (reset_dc) begin
            {m_dc_hold, m_opt_hold, m_dc_since, m_opt_since} = '0;
            {m_meta, m_sync, m_prev} = 6'b111111;
            {m_rs_q, m_rs_prev} = 2'b00;
            {m_led_cnt, m_cnt54, m_cnthdmi, m_cntrs} = '0;
            m_state = LED_NO_PLL;
            m_pin   = '0;
        end else begin
            m_state = nxt;
            m_pin   = pin_n;
            if (fall[0]) m_cnt54 = m_cnt54 + 1'b1;
            if (fall[1]) m_cnthdmi = m_cnthdmi + 1'b1;
            if (rise) m_cntrs = m_cntrs + 1'b1;
            m_prev    = m_sync;
            m_sync    = m_meta;
            m_meta    = {pll_hdmi_locked, pll54_locked};
            m_rs_prev = m_rs_q;
            m_rs_q    = resync;
            m_led_cnt = m_led_cnt + 1'b1;
            stretch_hold(dc_reset_request, m_dc_hold, m_dc_since);
            stretch_hold(opt_reset_request, m_opt_hold, m_opt_since);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks and stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    task compare_outputs;
        open_drain_t dc_exp;
        dc_exp = '{drive_en: m_dc_hold, level: 1'b0};
        if (dc_nreset !== dc_exp) begin
            dc_errors++;
            $display("ERR %0t dc_nreset expected %b actual %b", $time, dc_exp, dc_nreset);
        end
        if (status_pin !== m_pin) begin
            pin_errors++;
            $display("ERR %0t status_pin expected %b actual %b", $time, m_pin, status_pin);
        end
        if (event_counts.pll54_losses !== m_cnt54) begin
            count_errors++;
            $display("ERR %0t event_counts.pll54_losses expected %0d actual %0d",
                     $time, m_cnt54, event_counts.pll54_losses);
        end
        if (event_counts.pll_hdmi_losses !== m_cnthdmi) begin
            count_errors++;
            $display("ERR %0t event_counts.pll_hdmi_losses expected %0d actual %0d",
                     $time, m_cnthdmi, event_counts.pll_hdmi_losses);
        end
        if (event_counts.resyncs !== m_cntrs) begin
            count_errors++;
            $display("ERR %0t event_counts.resyncs expected %0d actual %0d",
                     $time, m_cntrs, event_counts.resyncs);
        end
    endtask

    // model steps on the rising edge and outputs are compared on the falling one
    task run_cycles(input int n);
        repeat (n) begin
            @(posedge control_clock);
            update_model();
            @(negedge control_clock);
            compare_outputs();
        end
    endtask

    task set_monitor_inputs(input logic l54, input logic lhdmi, input logic rs);
        if (pll54_locked && !l54) driven_54_falls++;
        if (pll_hdmi_locked && !lhdmi) driven_hdmi_falls++;
        if (!resync && rs) driven_rises++;
        pll54_locked    = l54;
        pll_hdmi_locked = lhdmi;
        resync          = rs;
    endtask

    task automatic drive_request(input bit use_opt, input logic level, input bit noise);
        logic other;
        other = noise && (rand_below(8) == 0);
        dc_reset_request  = use_opt ? other : level;
        opt_reset_request = use_opt ? level : other;
    endtask

    // gaps under the hold time retrigger a line that is still low
    task automatic pulse_requests(input int pulses, input bit use_opt, input bit noise);
        int len;
        int gap;
        repeat (pulses) begin
            len = 1 + rand_below(4);
            gap = rand_below(60);
            repeat (len) begin
                drive_request(use_opt, 1'b1, noise);
                run_cycles(1);
            end
            repeat (gap) begin
                drive_request(use_opt, 1'b0, noise);
                run_cycles(1);
            end
        end
        dc_reset_request  = 1'b0;
        opt_reset_request = 1'b0;
        run_cycles(HOLD_CYCLES + 3);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed = 38722;
        {cycle_count, dc_errors, pin_errors, count_errors} = '0;
        {driven_54_falls, driven_hdmi_falls, driven_rises} = '0;
        reset_dc          = 1'b1;
        dc_reset_request  = 1'b0;
        opt_reset_request = 1'b0;
        pin_mode          = PIN_LED;
        pll54_locked      = 1'b1;
        pll_hdmi_locked   = 1'b1;
        resync            = 1'b0;
        force_generate    = 1'b0;
        encoder_ready     = 1'b0;
        run_cycles(2);
        reset_dc = 1'b0;

        pulse_requests(8, 1'b0, 1'b0);
        pin_mode = PIN_GDEMU;
        pulse_requests(4, 1'b1, 1'b1);
        pin_mode = PIN_MODE;
        pulse_requests(4, 1'b1, 1'b1);
        pin_mode = PIN_USBGDROM;
        pulse_requests(5, 1'b0, 1'b1);

        // each led priority setting held past the sync latency
        pin_mode = PIN_LED;
        repeat (60) begin
            set_monitor_inputs(rand_below(4) != 0, rand_below(4) != 0, rand_below(3) == 0);
            force_generate = rand_below(2);
            encoder_ready  = rand_below(2);
            run_cycles(4 + rand_below(8));
        end

        repeat (80) begin
            set_monitor_inputs(rand_below(2), rand_below(2), rand_below(2));
            run_cycles(1 + rand_below(4));
        end
        set_monitor_inputs(1'b1, 1'b1, 1'b0);
        run_cycles(6);

        if (event_counts.pll54_losses !== event_count_t'(driven_54_falls)) begin
            count_errors++;
            $display("ERR %0t event_counts.pll54_losses expected %0d actual %0d",
                     $time, driven_54_falls, event_counts.pll54_losses);
        end
        if (event_counts.pll_hdmi_losses !== event_count_t'(driven_hdmi_falls)) begin
            count_errors++;
            $display("ERR %0t event_counts.pll_hdmi_losses expected %0d actual %0d",
                     $time, driven_hdmi_falls, event_counts.pll_hdmi_losses);
        end
        if (event_counts.resyncs !== event_count_t'(driven_rises)) begin
            count_errors++;
            $display("ERR %0t event_counts.resyncs expected %0d actual %0d",
                     $time, driven_rises, event_counts.resyncs);
        end

        $display("errors: dc_nreset %0d, status_pin %0d, event_counts %0d",
                 dc_errors, pin_errors, count_errors);
        if (dc_errors + pin_errors + count_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/supervisor_pkg.sv
source/console_reset_timer.sv
source/led_pattern_gen.sv
source/status_led_fsm.sv
source/lockloss_monitor.sv
source/control_supervisor.sv
tests/tb_control_supervisor.sv
